/* soc_harness.f */
+incdir+testbench
hw/soc_harness_pkg.sv
hw/harness_ctrl.sv
hw/dm_regs.sv
hw/mem_addr_decode.sv
hw/boot_rom.sv
hw/main_sram.sv
hw/soc_harness.sv
testbench/tb_soc_harness.sv

/* hw/boot_rom.hex */
// One 64-bit boot ROM word per line, word index 0 first
00000297_02028293
0002a303_00030067
f1402573_00000597
0185b583_0005b023
10500073_ffdff06f
00001537_80050513
7b241073_7b351073
deadbeef_0badc0de
13579bdf_2468ace0
0f1e2d3c_4b5a6978
8796a5b4_c3d2e1f0
55aa33cc_0ff0f00f
a5a5a5a5_5a5a5a5a
00000013_00000013
c001d00d_feedf00d
00000073_0000006f

/* testbench/tb_harness_model.svh */
// ----------------------------------------
// Reference model for the harness test.
// Expects TbNumWords and the DUT signals
// to be declared before it is included.
// ROM contents come from hw/boot_rom.hex.
// ----------------------------------------
`ifndef TB_HARNESS_MODEL_SVH
`define TB_HARNESS_MODEL_SVH

  // Debug register state
  dmi_data_t data0_m;
  logic      halt_m;
  logic      ndm_m;
  logic      act_m;

  data_t rom_model [RomWords];
  data_t sram_model [TbNumWords];

  initial begin
    $readmemh("hw/boot_rom.hex", rom_model);
  end

  task automatic reset_dm_model();
    data0_m = '0;
    halt_m  = 1'b0;
    ndm_m   = 1'b0;
    act_m   = 1'b0;
  endtask

  // Data a DMI request returns, taken before any write lands
  function automatic dmi_data_t dm_expect_read(input dmi_req_t req);
    dmi_data_t ctrl;
    ctrl              = '0;
    ctrl[HaltReqBit]  = halt_m;
    ctrl[NdmResetBit] = ndm_m;
    ctrl[DmActiveBit] = act_m;
    if (req.op != DMI_READ) return '0;
    if (req.addr == DmData0Addr) return data0_m;
    if (req.addr == DmControlAddr) return ctrl;
    return '0;
  endfunction

  task automatic dm_apply_write(input dmi_req_t req);
    if (req.op == DMI_WRITE && req.addr == DmData0Addr) begin
      data0_m = req.data;
    end
    if (req.op == DMI_WRITE && req.addr == DmControlAddr) begin
      halt_m = req.data[HaltReqBit];
      ndm_m  = req.data[NdmResetBit];
      act_m  = req.data[DmActiveBit];
    end
  endtask

  // Expected response of one accepted memory request
  task automatic mem_model_access(input mem_req_t req, output logic exp_err,
                                  output data_t exp_rdata);
    addr_t rom_off;
    addr_t sram_off;
    rom_off   = req.addr - RomBase;
    sram_off  = req.addr - DramBase;
    exp_err   = 1'b0;
    exp_rdata = '0;
    if (rom_off < RomWords * 8) begin
      if (!req.we) exp_rdata = rom_model[rom_off >> 3];
    end else if (sram_off < TbNumWords * 8) begin
      if (req.we) begin
        for (int b = 0; b < 8; b++) begin
          if (req.be[b]) sram_model[sram_off >> 3][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end else begin
        exp_rdata = sram_model[sram_off >> 3];
      end
    end else begin
      exp_err = 1'b1;
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    assert (got === exp) else begin
      $display("** Error: %s expected %h actual %h", name, exp, got);
      stop_with_failure();
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      $display("Error: %s", what);
      stop_with_failure();
    end
  endtask

`endif

/* testbench/tb_soc_harness.sv */
// ----------------------------------------
// Testbench for soc_harness with random
// DMI and memory traffic from a fixed seed.
// Run from the project root so that the
// boot ROM hex file is found.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_soc_harness;

  import soc_harness_pkg::*;

  localparam int unsigned TbNumWords    = 64;
  localparam int unsigned TbDelayCycles = 24;
  localparam int unsigned NumDmiOps     = 120;
  localparam int unsigned NumMemOps     = 300;
  // About ten times the expected length of all tests
  localparam int unsigned TimeoutCycles =
    10 * (8 + 2 * TbDelayCycles + 12 * NumDmiOps + 3 * TbNumWords + NumMemOps + 64);

  logic        clk_i;
  logic        ndmreset_n;
  logic        jtag_sel_i;
  dmi_req_t    jtag_req_i;
  logic        jtag_req_valid_i;
  logic        jtag_req_ready_o;
  logic        jtag_resp_valid_o;
  logic        jtag_resp_ready_i;
  logic [31:0] jtag_exit_i;
  dmi_req_t    dtm_req_i;
  logic        dtm_req_valid_i;
  logic        dtm_req_ready_o;
  logic        dtm_resp_valid_o;
  logic        dtm_resp_ready_i;
  logic [31:0] dtm_exit_i;
  dmi_resp_t   dmi_resp_o;
  logic [31:0] exit_o;
  logic        debug_req_o;
  logic [31:0] cycles_o;
  mem_req_t    mem_req_i;
  mem_resp_t   mem_resp_o;

  integer      seed = 32'h9b42;
  int unsigned run_cycles = 0;
  int unsigned since_rst;
  logic        pend_valid;
  logic        pend_err;
  data_t       pend_rdata;

  `include "tb_harness_model.svh"

  soc_harness #(
    .NumWords    ( TbNumWords    ),
    .DelayCycles ( TbDelayCycles )
  ) UUT (
    .clk_i             ( clk_i             ),
    .ndmreset_n        ( ndmreset_n        ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .dmi_resp_o        ( dmi_resp_o        ),
    .exit_o            ( exit_o            ),
    .debug_req_o       ( debug_req_o       ),
    .cycles_o          ( cycles_o          ),
    .mem_req_i         ( mem_req_i         ),
    .mem_resp_o        ( mem_resp_o        )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= TimeoutCycles) begin
      $display("Error: run did not finish within %0d cycles", TimeoutCycles);
      stop_with_failure();
    end
  end

  // Clock edges since ndmreset_n was released
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) since_rst <= 0;
    else since_rst <= since_rst + 1;
  end

  task automatic stop_with_failure();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped after the first error");
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  task automatic apply_reset();
    ndmreset_n = 1'b0;
    reset_dm_model();
    repeat (8) @(negedge clk_i);
    ndmreset_n = 1'b1;
  endtask

  // The cycle counter leaves zero once the system reset is released
  task automatic wait_system_release();
    int unsigned waited;
    waited = 0;
    while (cycles_o == 0) begin
      @(negedge clk_i);
      waited++;
      check_true(waited <= 4, "cycle counter did not start after system reset release");
    end
  endtask

  task automatic check_idle_port(input logic use_jtag);
    if (use_jtag) begin
      check_value("dtm ready while unselected", 0, dtm_req_ready_o);
      check_value("dtm resp_valid while unselected", 0, dtm_resp_valid_o);
    end else begin
      check_value("jtag ready while unselected", 0, jtag_req_ready_o);
      check_value("jtag resp_valid while unselected", 0, jtag_resp_valid_o);
    end
  endtask

  // One DMI transfer through the chosen port with the response held for resp_delay cycles
  task automatic dmi_access(input logic use_jtag, input dmi_op_e op, input dmi_addr_t addr,
                            input dmi_data_t wdata, input int unsigned resp_delay);
    dmi_req_t    req;
    dmi_data_t   exp_data;
    logic        accepted;
    int unsigned i;
    req.addr = addr;
    req.op   = op;
    req.data = wdata;
    if (jtag_sel_i !== use_jtag) begin
      jtag_sel_i = use_jtag;
      @(negedge clk_i);
    end
    if (use_jtag) begin
      jtag_req_i       = req;
      jtag_req_valid_i = 1'b1;
    end else begin
      dtm_req_i       = req;
      dtm_req_valid_i = 1'b1;
    end
    accepted = 1'b0;
    while (!accepted) begin
      accepted = use_jtag ? jtag_req_ready_o : dtm_req_ready_o;
      @(negedge clk_i);
      check_idle_port(use_jtag);
    end
    exp_data = dm_expect_read(req);
    dm_apply_write(req);
    jtag_req_valid_i = 1'b0;
    dtm_req_valid_i  = 1'b0;
    for (i = 0; i <= resp_delay; i++) begin
      check_value("dmi resp_valid", 1, use_jtag ? jtag_resp_valid_o : dtm_resp_valid_o);
      check_value("dmi ready while busy", 0, use_jtag ? jtag_req_ready_o : dtm_req_ready_o);
      check_value("dmi rdata", exp_data, dmi_resp_o.data);
      check_value("dmi resp code", 0, dmi_resp_o.resp);
      if (i == resp_delay) begin
        jtag_resp_ready_i = use_jtag;
        dtm_resp_ready_i  = ~use_jtag;
      end
      @(negedge clk_i);
      check_idle_port(use_jtag);
    end
    jtag_resp_ready_i = 1'b0;
    dtm_resp_ready_i  = 1'b0;
    check_value("dmi resp_valid after handshake", 0,
                use_jtag ? jtag_resp_valid_o : dtm_resp_valid_o);
  endtask

  function automatic mem_req_t build_mem_req(input logic we, input addr_t addr,
                                             input be_t be, input data_t wdata);
    mem_req_t req;
    req.req   = 1'b1;
    req.we    = we;
    req.addr  = addr;
    req.be    = be;
    req.wdata = wdata;
    return req;
  endfunction

  function automatic mem_req_t make_mem_req();
    mem_req_t req;
    addr_t    addr;
    case (rand_below(10))
      0, 1:          addr = RomBase + rand_below(RomWords * 8);
      2, 3, 4, 5, 6: addr = DramBase + rand_below(TbNumWords * 8);
      7:             addr = DramBase + TbNumWords * 8 + rand_below(64);
      8:             addr = RomBase - 8 + rand_below(8);
      default:       addr = $random(seed);
    endcase
    req = build_mem_req(rand_below(2) == 1, addr, be_t'($random(seed)),
                        {$random(seed), $random(seed)});
    req.req = rand_below(6) != 0;
    return req;
  endfunction

  // Checks the response to the previous request, then drives the next one
  task automatic mem_step(input mem_req_t req, input logic in_reset);
    logic  exp_err;
    data_t exp_rdata;
    check_value("mem rvalid", pend_valid, mem_resp_o.rvalid);
    if (pend_valid) begin
      check_value("mem err", pend_err, mem_resp_o.err);
      check_value("mem rdata", pend_rdata, mem_resp_o.rdata);
    end
    mem_req_i  = req;
    pend_valid = req.req && !in_reset;
    if (pend_valid) begin
      mem_model_access(req, exp_err, exp_rdata);
      pend_err   = exp_err;
      pend_rdata = exp_rdata;
    end
    @(negedge clk_i);
  endtask

  initial begin
    int unsigned i;
    logic [31:0] prev_cycles;
    addr_t       word_addr;
    dmi_addr_t   addr;
    dmi_op_e     op;

    ndmreset_n        = 1'b0;
    jtag_sel_i        = 1'b1;
    jtag_req_i        = '0;
    jtag_req_valid_i  = 1'b0;
    jtag_resp_ready_i = 1'b0;
    jtag_exit_i       = '0;
    dtm_req_i         = '0;
    dtm_req_valid_i   = 1'b0;
    dtm_resp_ready_i  = 1'b0;
    dtm_exit_i        = '0;
    mem_req_i         = '0;
    pend_valid        = 1'b0;
    apply_reset();

    // ----------------------------------------
    // After reset
    // ----------------------------------------
    for (i = 0; i < 2; i++) begin
      jtag_sel_i  = i[0];
      jtag_exit_i = $random(seed);
      dtm_exit_i  = $random(seed);
      @(negedge clk_i);
      check_value("debug_req_o after reset", 0, debug_req_o);
      check_value("jtag resp_valid after reset", 0, jtag_resp_valid_o);
      check_value("dtm resp_valid after reset", 0, dtm_resp_valid_o);
      check_value("mem rvalid after reset", 0, mem_resp_o.rvalid);
      check_value("selected ready after reset", 1,
                  jtag_sel_i ? jtag_req_ready_o : dtm_req_ready_o);
      check_value("exit_o", jtag_sel_i ? jtag_exit_i : dtm_exit_i, exit_o);
      check_idle_port(jtag_sel_i);
    end

    // ----------------------------------------
    // Delay window
    // ----------------------------------------
    dmi_access(1'b1, DMI_WRITE, DmControlAddr, 32'h8000_0001, 0);
    check_true(since_rst < TbDelayCycles, "haltreq was set after the delay window ended");
    while (since_rst < TbDelayCycles + 4) begin
      check_value("debug_req_o in delay window", since_rst >= TbDelayCycles, debug_req_o);
      @(negedge clk_i);
    end
    dmi_access(1'b0, DMI_WRITE, DmControlAddr, 32'h0000_0001, 1);
    check_value("debug_req_o after haltreq clear", 0, debug_req_o);

    // ----------------------------------------
    // DMI access through both transports
    // ----------------------------------------
    for (i = 0; i < NumDmiOps; i++) begin
      case (rand_below(3))
        0:       op = DMI_NOP;
        1:       op = DMI_READ;
        default: op = DMI_WRITE;
      endcase
      case (rand_below(5))
        0, 1:    addr = DmData0Addr;
        2, 3:    addr = DmControlAddr;
        default: addr = dmi_addr_t'(rand_below(128));
      endcase
      dmi_access(rand_below(2) == 1, op, addr, dmi_data_t'($random(seed)), rand_below(4));
    end
    dmi_access(1'b1, DMI_WRITE, DmControlAddr, 32'h0, 0);
    // Random dmcontrol writes may have left the system in reset
    wait_system_release();

    // ----------------------------------------
    // Memory decode
    // ----------------------------------------
    for (i = 0; i < TbNumWords; i++) begin
      word_addr = DramBase + 8 * i;
      mem_step(build_mem_req(1'b1, word_addr, 8'hff, {~word_addr, word_addr ^ 32'h5a5a_0f0f}),
               1'b0);
    end
    for (i = 0; i < NumMemOps; i++) begin
      mem_step(make_mem_req(), 1'b0);
    end
    // ROM write is dropped
    mem_step(build_mem_req(1'b1, RomBase + 40, 8'hff, '1), 1'b0);
    mem_step(build_mem_req(1'b0, RomBase + 40, 8'h00, '0), 1'b0);
    mem_step('0, 1'b0);

    // ----------------------------------------
    // Non-debug reset
    // ----------------------------------------
    dmi_access(1'b1, DMI_WRITE, DmControlAddr, 32'h0000_0003, 0);
    for (i = 0; i < 8; i++) begin
      check_value("cycles_o in system reset", 0, cycles_o);
      mem_step(make_mem_req(), 1'b1);
    end
    mem_step('0, 1'b1);
    dmi_access(1'b0, DMI_WRITE, DmControlAddr, 32'h0000_0001, 2);
    wait_system_release();
    check_value("first cycles_o", 1, cycles_o);
    prev_cycles = cycles_o;
    for (i = 0; i < 10; i++) begin
      @(negedge clk_i);
      check_value("cycles_o step", prev_cycles + 1, cycles_o);
      prev_cycles = cycles_o;
    end
    for (i = 0; i < TbNumWords; i++) begin
      mem_step(build_mem_req(1'b0, DramBase + 8 * i, 8'h00, '0), 1'b0);
    end
    mem_step('0, 1'b0);
    mem_step('0, 1'b0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/soc_harness.sv */
// ----------------------------------------
// Debug and memory fabric of the harness.
// Both DMI transports share dmi_resp_o and
// only the selected one sees valid.
// Memory side runs on the system reset.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_harness #(
  parameter int unsigned NumWords    = 1024,
  parameter int unsigned DelayCycles = 500
) (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire logic                       jtag_sel_i,
  input  wire soc_harness_pkg::dmi_req_t  jtag_req_i,
  input  wire logic                       jtag_req_valid_i,
  output      logic                       jtag_req_ready_o,
  output      logic                       jtag_resp_valid_o,
  input  wire logic                       jtag_resp_ready_i,
  input  wire logic [31:0]                jtag_exit_i,
  input  wire soc_harness_pkg::dmi_req_t  dtm_req_i,
  input  wire logic                       dtm_req_valid_i,
  output      logic                       dtm_req_ready_o,
  output      logic                       dtm_resp_valid_o,
  input  wire logic                       dtm_resp_ready_i,
  input  wire logic [31:0]                dtm_exit_i,
  output      soc_harness_pkg::dmi_resp_t dmi_resp_o,
  output      logic [31:0]                exit_o,
  output      logic                       debug_req_o,
  output      logic [31:0]                cycles_o,
  input  wire soc_harness_pkg::mem_req_t  mem_req_i,
  output      soc_harness_pkg::mem_resp_t mem_resp_o
);

  import soc_harness_pkg::*;

  dmi_req_t dm_req;
  logic     dm_req_valid;
  logic     dm_req_ready;
  logic     dm_resp_valid;
  logic     dm_resp_ready;
  logic     haltreq;
  logic     ndmreset;
  logic     sys_rst_n;
  mem_req_t rom_req;
  mem_req_t sram_req;
  data_t    rom_rdata;
  data_t    sram_rdata;

  // ----------------------------------------
  // Debug side
  // ----------------------------------------
  harness_ctrl #(
    .DelayCycles ( DelayCycles )
  ) i_harness_ctrl (
    .clk_i             ( clk_i             ),
    .ndmreset_n        ( ndmreset_n        ),
    .jtag_sel_i        ( jtag_sel_i        ),
    .jtag_req_i        ( jtag_req_i        ),
    .jtag_req_valid_i  ( jtag_req_valid_i  ),
    .jtag_req_ready_o  ( jtag_req_ready_o  ),
    .jtag_resp_valid_o ( jtag_resp_valid_o ),
    .jtag_resp_ready_i ( jtag_resp_ready_i ),
    .jtag_exit_i       ( jtag_exit_i       ),
    .dtm_req_i         ( dtm_req_i         ),
    .dtm_req_valid_i   ( dtm_req_valid_i   ),
    .dtm_req_ready_o   ( dtm_req_ready_o   ),
    .dtm_resp_valid_o  ( dtm_resp_valid_o  ),
    .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
    .dtm_exit_i        ( dtm_exit_i        ),
    .exit_o            ( exit_o            ),
    .dm_req_o          ( dm_req            ),
    .dm_req_valid_o    ( dm_req_valid      ),
    .dm_req_ready_i    ( dm_req_ready      ),
    .dm_resp_valid_i   ( dm_resp_valid     ),
    .dm_resp_ready_o   ( dm_resp_ready     ),
    .haltreq_i         ( haltreq           ),
    .ndmreset_req_i    ( ndmreset          ),
    .debug_req_o       ( debug_req_o       ),
    .sys_rst_no        ( sys_rst_n         ),
    .cycles_o          ( cycles_o          )
  );

  dm_regs i_dm_regs (
    .clk_i            ( clk_i         ),
    .ndmreset_n       ( ndmreset_n    ),
    .dmi_req_i        ( dm_req        ),
    .dmi_req_valid_i  ( dm_req_valid  ),
    .dmi_req_ready_o  ( dm_req_ready  ),
    .dmi_resp_o       ( dmi_resp_o    ),
    .dmi_resp_valid_o ( dm_resp_valid ),
    .dmi_resp_ready_i ( dm_resp_ready ),
    .haltreq_o        ( haltreq       ),
    .ndmreset_o       ( ndmreset      )
  );

  // ----------------------------------------
  // Memory side
  // ----------------------------------------
  mem_addr_decode #(
    .NumWords ( NumWords )
  ) i_mem_addr_decode (
    .clk_i        ( clk_i      ),
    .sys_rst_ni   ( sys_rst_n  ),
    .mem_req_i    ( mem_req_i  ),
    .mem_resp_o   ( mem_resp_o ),
    .rom_req_o    ( rom_req    ),
    .rom_rdata_i  ( rom_rdata  ),
    .sram_req_o   ( sram_req   ),
    .sram_rdata_i ( sram_rdata )
  );

  boot_rom i_boot_rom (
    .clk_i     ( clk_i     ),
    .rom_req_i ( rom_req   ),
    .rdata_o   ( rom_rdata )
  );

  main_sram #(
    .NumWords ( NumWords )
  ) i_main_sram (
    .clk_i      ( clk_i      ),
    .sram_req_i ( sram_req   ),
    .rdata_o    ( sram_rdata )
  );

endmodule

`default_nettype wire

/* hw/main_sram.sv */
// ----------------------------------------
// Single-port SRAM with byte enables.
// Address is a word index, read data one
// cycle after req. No reset on contents.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module main_sram #(
  parameter int unsigned NumWords = 1024
) (
  input  wire logic                      clk_i,
  input  wire soc_harness_pkg::mem_req_t sram_req_i,
  output      soc_harness_pkg::data_t    rdata_o
);

  import soc_harness_pkg::*;

  localparam int unsigned IdxW = $clog2(NumWords);

  data_t           mem [NumWords];
  logic [IdxW-1:0] idx;

  assign idx = sram_req_i.addr[IdxW-1:0];

  always_ff @(posedge clk_i) begin
    if (sram_req_i.req && sram_req_i.we) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (sram_req_i.be[b]) begin
          mem[idx][8*b +: 8] <= sram_req_i.wdata[8*b +: 8];
        end
      end
    end else if (sram_req_i.req) begin
      rdata_o <= mem[idx];
    end
  end

endmodule

`default_nettype wire

/* hw/boot_rom.sv */
// ----------------------------------------
// Boot ROM loaded from hw/boot_rom.hex,
// read path relative to the run directory.
// Address is a word index, data one cycle
// after req.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module boot_rom (
  input  wire logic                      clk_i,
  input  wire soc_harness_pkg::mem_req_t rom_req_i,
  output      soc_harness_pkg::data_t    rdata_o
);

  import soc_harness_pkg::*;

  localparam int unsigned IdxW = $clog2(RomWords);

  data_t mem [RomWords];

  initial begin
    $readmemh("hw/boot_rom.hex", mem);
  end

  // Write requests read harmlessly and are discarded upstream
  always_ff @(posedge clk_i) begin
    if (rom_req_i.req) begin
      rdata_o <= mem[rom_req_i.addr[IdxW-1:0]];
    end
  end

endmodule

`default_nettype wire

/* hw/mem_addr_decode.sv */
// ----------------------------------------
// Decodes the memory port into boot ROM
// and main SRAM. Every accepted request
// gets one rvalid on the next cycle.
// Unmapped addresses return err, and ROM
// writes are dropped without an error.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mem_addr_decode #(
  parameter int unsigned NumWords = 1024
) (
  input  wire logic                       clk_i,
  input  wire logic                       sys_rst_ni,
  input  wire soc_harness_pkg::mem_req_t  mem_req_i,
  output      soc_harness_pkg::mem_resp_t mem_resp_o,
  output      soc_harness_pkg::mem_req_t  rom_req_o,
  input  wire soc_harness_pkg::data_t     rom_rdata_i,
  output      soc_harness_pkg::mem_req_t  sram_req_o,
  input  wire soc_harness_pkg::data_t     sram_rdata_i
);

  import soc_harness_pkg::*;

  localparam int unsigned OffBits = $clog2($bits(be_t));

  addr_t rom_off;
  addr_t sram_off;
  logic  rom_hit;
  logic  sram_hit;
  logic  accept;
  logic  rvalid_q;
  logic  rom_q;
  logic  sram_q;
  logic  we_q;

  // No requests taken while the system is held in reset
  assign accept   = mem_req_i.req & sys_rst_ni;
  assign rom_off  = mem_req_i.addr - RomBase;
  assign sram_off = mem_req_i.addr - DramBase;
  assign rom_hit  = rom_off < addr_t'(RomWords * 8);
  assign sram_hit = sram_off < addr_t'(NumWords * 8);

  always_comb begin
    rom_req_o       = mem_req_i;
    rom_req_o.req   = accept & rom_hit;
    rom_req_o.addr  = rom_off >> OffBits;
    sram_req_o      = mem_req_i;
    sram_req_o.req  = accept & sram_hit;
    sram_req_o.addr = sram_off >> OffBits;
  end

  // Region of the request now in the memories
  always_ff @(posedge clk_i or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      rvalid_q <= 1'b0;
      rom_q    <= 1'b0;
      sram_q   <= 1'b0;
      we_q     <= 1'b0;
    end else begin
      rvalid_q <= accept;
      rom_q    <= accept & rom_hit;
      sram_q   <= accept & sram_hit;
      we_q     <= accept & mem_req_i.we;
    end
  end

  always_comb begin
    mem_resp_o.rvalid = rvalid_q;
    mem_resp_o.err    = rvalid_q & ~rom_q & ~sram_q;
    mem_resp_o.rdata  = '0;
    if (!we_q && rom_q) begin
      mem_resp_o.rdata = rom_rdata_i;
    end else if (!we_q && sram_q) begin
      mem_resp_o.rdata = sram_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* hw/dm_regs.sv */
// ----------------------------------------
// Minimal debug module register file.
// Holds data0 and three dmcontrol bits.
// One DMI request in flight at a time, and
// responses always report success.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dm_regs (
  input  wire logic                       clk_i,
  input  wire logic                       ndmreset_n,
  input  wire soc_harness_pkg::dmi_req_t  dmi_req_i,
  input  wire logic                       dmi_req_valid_i,
  output      logic                       dmi_req_ready_o,
  output      soc_harness_pkg::dmi_resp_t dmi_resp_o,
  output      logic                       dmi_resp_valid_o,
  input  wire logic                       dmi_resp_ready_i,
  output      logic                       haltreq_o,
  output      logic                       ndmreset_o
);

  import soc_harness_pkg::*;

  dmi_data_t data0_q;
  logic      haltreq_q;
  logic      ndmreset_q;
  logic      dmactive_q;
  logic      resp_valid_q;
  dmi_data_t resp_data_q;
  dmi_data_t ctrl_rd;
  dmi_data_t rd_data;
  logic      accept;

  // Busy until the response has been taken
  assign dmi_req_ready_o = ~resp_valid_q;
  assign accept          = dmi_req_valid_i & ~resp_valid_q;

  always_comb begin
    ctrl_rd              = '0;
    ctrl_rd[HaltReqBit]  = haltreq_q;
    ctrl_rd[NdmResetBit] = ndmreset_q;
    ctrl_rd[DmActiveBit] = dmactive_q;
  end

  // Writes and NOPs return zero
  always_comb begin
    rd_data = '0;
    if (dmi_req_i.op == DMI_READ) begin
      case (dmi_req_i.addr)
        DmData0Addr:   rd_data = data0_q;
        DmControlAddr: rd_data = ctrl_rd;
        default:       rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      data0_q      <= '0;
      haltreq_q    <= 1'b0;
      ndmreset_q   <= 1'b0;
      dmactive_q   <= 1'b0;
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
      if (dmi_req_i.op == DMI_WRITE && dmi_req_i.addr == DmData0Addr) begin
        data0_q <= dmi_req_i.data;
      end
      if (dmi_req_i.op == DMI_WRITE && dmi_req_i.addr == DmControlAddr) begin
        haltreq_q  <= dmi_req_i.data[HaltReqBit];
        ndmreset_q <= dmi_req_i.data[NdmResetBit];
        dmactive_q <= dmi_req_i.data[DmActiveBit];
      end
    end else if (dmi_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= rd_data;
    end
  end

  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_o.data  = resp_data_q;
  assign dmi_resp_o.resp  = 2'b00;

  // Outputs only act while the module is active
  assign haltreq_o  = haltreq_q & dmactive_q;
  assign ndmreset_o = ndmreset_q & dmactive_q;

endmodule

`default_nettype wire

/* hw/harness_ctrl.sv */
// ----------------------------------------
// Debug transport select, halt request
// delay window, system reset and cycle
// counter.
// jtag_sel_i must stay stable while a DMI
// request is outstanding.
// ----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module harness_ctrl #(
  parameter int unsigned DelayCycles = 500
) (
  input  wire logic                      clk_i,
  input  wire logic                      ndmreset_n,
  input  wire logic                      jtag_sel_i,
  input  wire soc_harness_pkg::dmi_req_t jtag_req_i,
  input  wire logic                      jtag_req_valid_i,
  output      logic                      jtag_req_ready_o,
  output      logic                      jtag_resp_valid_o,
  input  wire logic                      jtag_resp_ready_i,
  input  wire logic [31:0]               jtag_exit_i,
  input  wire soc_harness_pkg::dmi_req_t dtm_req_i,
  input  wire logic                      dtm_req_valid_i,
  output      logic                      dtm_req_ready_o,
  output      logic                      dtm_resp_valid_o,
  input  wire logic                      dtm_resp_ready_i,
  input  wire logic [31:0]               dtm_exit_i,
  output      logic [31:0]               exit_o,
  output      soc_harness_pkg::dmi_req_t dm_req_o,
  output      logic                      dm_req_valid_o,
  input  wire logic                      dm_req_ready_i,
  input  wire logic                      dm_resp_valid_i,
  output      logic                      dm_resp_ready_o,
  input  wire logic                      haltreq_i,
  input  wire logic                      ndmreset_req_i,
  output      logic                      debug_req_o,
  output      logic                      sys_rst_no,
  output      logic [31:0]               cycles_o
);

  logic [31:0] dly_cnt_q;
  logic        rst_src_n;
  logic [1:0]  rst_sync_q;

  // ----------------------------------------
  // Transport mux
  // ----------------------------------------
  assign dm_req_o        = jtag_sel_i ? jtag_req_i        : dtm_req_i;
  assign dm_req_valid_o  = jtag_sel_i ? jtag_req_valid_i  : dtm_req_valid_i;
  assign dm_resp_ready_o = jtag_sel_i ? jtag_resp_ready_i : dtm_resp_ready_i;
  assign exit_o          = jtag_sel_i ? jtag_exit_i       : dtm_exit_i;

  // Unselected side never sees a handshake
  assign jtag_req_ready_o  = jtag_sel_i & dm_req_ready_i;
  assign dtm_req_ready_o   = ~jtag_sel_i & dm_req_ready_i;
  assign jtag_resp_valid_o = jtag_sel_i & dm_resp_valid_i;
  assign dtm_resp_valid_o  = ~jtag_sel_i & dm_resp_valid_i;

  // ----------------------------------------
  // Delay window
  // ----------------------------------------
  // Gives boot code time to run before the first halt
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dly_cnt_q <= 32'(DelayCycles);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 32'd1;
    end
  end

  assign debug_req_o = haltreq_i & (dly_cnt_q == '0);

  // ----------------------------------------
  // System reset
  // ----------------------------------------
  // Asserts at once, releases after two clock edges
  assign rst_src_n = ndmreset_n & ~ndmreset_req_i;

  always_ff @(posedge clk_i or negedge rst_src_n) begin
    if (!rst_src_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = rst_sync_q[1];

  // Free running from system reset release
  always_ff @(posedge clk_i or negedge sys_rst_no) begin
    if (!sys_rst_no) begin
      cycles_o <= '0;
    end else begin
      cycles_o <= cycles_o + 32'd1;
    end
  end

endmodule

`default_nettype wire

/* hw/soc_harness_pkg.sv */
// ----------------------------------------
// Shared widths, DMI types, memory port
// structs and the address map.
// Memory words are 64 bits with 8 byte
// enables, and addresses are byte addresses.
// ----------------------------------------
`default_nettype none

package soc_harness_pkg;

  // Memory side widths
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  be_t;

  // Debug module interface
  typedef logic [6:0]  dmi_addr_t;
  typedef logic [31:0] dmi_data_t;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'h0,
    DMI_READ  = 2'h1,
    DMI_WRITE = 2'h2
  } dmi_op_e;

  typedef struct packed {
    dmi_addr_t addr;
    dmi_op_e   op;
    dmi_data_t data;
  } dmi_req_t;

  typedef struct packed {
    dmi_data_t  data;
    logic [1:0] resp;
  } dmi_resp_t;

  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  rvalid;
    logic  err;
    data_t rdata;
  } mem_resp_t;

  // ----------------------------------------
  // Debug register map
  // ----------------------------------------
  localparam dmi_addr_t   DmData0Addr   = 7'h04;
  localparam dmi_addr_t   DmControlAddr = 7'h10;
  localparam int unsigned HaltReqBit    = 31;
  localparam int unsigned NdmResetBit   = 1;
  localparam int unsigned DmActiveBit   = 0;

  // ----------------------------------------
  // Address map
  // ----------------------------------------
  localparam addr_t       RomBase  = 32'h0001_0000;
  localparam int unsigned RomWords = 16;
  localparam addr_t       DramBase = 32'h8000_0000;

endpackage

`default_nettype wire
